// ==== build.f ====
cache_pkg.sv
mem_pkg.sv
sram_1rw.sv
cache_datapath.sv
cache_ctrl.sv
cache_top.sv
cache_properties.sv
tb_cache.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  - files:
      - cache_pkg.sv
      - mem_pkg.sv
      - sram_1rw.sv
      - cache_datapath.sv
      - cache_ctrl.sv
      - cache_top.sv
  - target: test
    files:
      - cache_properties.sv
      - tb_cache.sv

// ==== tb_cache.sv ====
`timescale 1ns/100ps

module tb_cache
  import cache_pkg::*, mem_pkg::*;
;

  logic     clk;
  logic     reset;
  logic     cpu_req_val;
  logic     cpu_req_rdy;
  cpu_req_t cpu_req;
  logic     cpu_resp_val;
  word_t    cpu_resp_data;
  logic     mem_req_val;
  logic     mem_req_rdy;
  mem_req_t mem_req;
  logic     mem_req_data_valid;
  logic     mem_req_data_ready;
  beat_t    mem_req_data_bits;
  logic     mem_resp_val;
  beat_t    mem_resp_data;

  beat_t       mem_store [logic [line_addr_bits+1:0]];  // Keyed by line and beat
  word_t       ref_mem [word_addr_t];
  int          cycle_count = 0;
  logic [31:0] rng_state = 32'd75;

  // Memory model state and request log
  int         wb_reqs = 0;
  int         fill_reqs = 0;
  int         wb_beats = 0;
  int         beats_at_fill = 0;
  int         stall_left = 0;
  int         fill_left = 0;
  logic       wb_active = 1'b0;
  logic [1:0] wb_idx = '0;
  line_addr_t wb_line;
  line_addr_t fill_line;

  cache_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Roughly 360 accesses of up to 30 cycles each plus the sweep
  initial begin : watchdog
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count == 40000) begin
        $display("Run timed out after %0d cycles without finishing", cycle_count);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
      end
    end
  end

  initial begin : assertion_monitor
    forever begin
      @(posedge clk);
      if (dut.props.assert_failures != 0) begin
        $display("A bound handshake assertion failed at %0t ns", $time);
        $display("Some tests failed");
        $fatal(1, "assertion failure");
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory and reference models
  //////////////////////////////////////////////////////////////////////

  function automatic word_t init_word(word_addr_t a);
    return word_t'(32'(a) * 32'h9E37 + 32'h55);
  endfunction

  function automatic beat_t mem_beat(line_addr_t line, logic [1:0] b);
    beat_t beat;
    if (mem_store.exists({line, b})) begin
      return mem_store[{line, b}];
    end
    for (int w = 0; w < words_per_beat; w++) begin
      beat[w*word_bits +: word_bits] = init_word({line, b, 2'(w)});
    end
    return beat;
  endfunction

  function automatic word_t mem_word(word_addr_t a);
    beat_t beat;
    beat = mem_beat(a[29:4], a[3:2]);
    return beat[a[1:0]*word_bits +: word_bits];
  endfunction

  function automatic word_t ref_word(word_addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
  endfunction

  function automatic void ref_write(word_addr_t a, word_t data, byte_mask_t mask);
    word_t w;
    w = ref_word(a);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        w[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    ref_mem[a] = w;
  endfunction

  // Samples handshakes at the falling edge and drives a little after the rising edge
  initial begin : memory_model
    int   req_wait;
    logic req_fire;
    logic beat_fire;
    req_wait = 0;
    forever begin
      @(negedge clk);
      req_fire  = mem_req_val && mem_req_rdy;
      beat_fire = mem_req_data_valid && mem_req_data_ready;
      if (beat_fire) begin
        mem_store[{wb_line, wb_idx}] = mem_req_data_bits;
        wb_beats++;
        if (wb_idx == 2'd3) wb_active = 1'b0;
        wb_idx++;
      end
      if (req_fire && mem_req.rw) begin
        wb_reqs++;
        wb_line   = mem_req.addr;
        wb_idx    = '0;
        wb_active = 1'b1;
      end else if (req_fire) begin
        fill_reqs++;
        fill_line     = mem_req.addr;
        fill_left     = beats_per_line;
        beats_at_fill = wb_beats;
      end
      req_wait = (mem_req_val && !mem_req_rdy) ? req_wait + 1 : 0;

      @(posedge clk);
      #1;
      mem_req_rdy = (req_wait >= 2);   // Fixed two-cycle accept delay
      if (wb_active && stall_left > 0) begin
        mem_req_data_ready = 1'b0;
        stall_left--;
      end else begin
        mem_req_data_ready = 1'b1;
      end
      if (fill_left > 0) begin
        mem_resp_val  = 1'b1;
        mem_resp_data = mem_beat(fill_line, 2'(beats_per_line - fill_left));
        fill_left--;
      end else begin
        mem_resp_val  = 1'b0;
        mem_resp_data = '0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_addr_t make_addr(tag_t tag, index_t index, logic [1:0] beat,
                                           logic [1:0] word);
    return {tag, index, beat, word};
  endfunction

  // Latency counts cycles from the accepting edge to the end of the access
  task automatic cpu_access(input word_addr_t addr, input word_t data, input byte_mask_t wmask,
                            output word_t rdata, output int latency);
    @(posedge clk);
    #1;
    cpu_req_val = 1'b1;
    cpu_req     = '{addr: addr, data: data, wmask: wmask};
    @(negedge clk);
    while (!cpu_req_rdy) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    cpu_req_val = 1'b0;
    latency = 1;
    @(negedge clk);
    while (!((wmask == '0) ? cpu_resp_val : cpu_req_rdy)) begin
      latency++;
      @(negedge clk);
    end
    rdata = cpu_resp_data;
  endtask

  task automatic read_check(input word_addr_t addr, input string what);
    word_t rdata;
    int    latency;
    cpu_access(addr, '0, '0, rdata, latency);
    check_value(what, rdata, ref_word(addr));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic read_miss_then_hit;
    word_addr_t a;
    word_t      rdata;
    int         latency;
    int         fills;
    int         wbs;
    a     = make_addr(18'h00123, 8'h10, 2'd2, 2'd1);
    fills = fill_reqs;
    wbs   = wb_reqs;
    cpu_access(a, '0, '0, rdata, latency);
    check_value("read miss data", rdata, init_word(a));
    check_value("refills on read miss", fill_reqs - fills, 1);
    check_value("write-backs on clean miss", wb_reqs - wbs, 0);
    check_value("refill line address", fill_line, a[29:4]);
    fills = fill_reqs;
    cpu_access(a, '0, '0, rdata, latency);
    check_value("read hit data", rdata, ref_word(a));
    check_value("read hit latency", latency, 1);
    check_value("memory requests on read hit", (fill_reqs - fills) + (wb_reqs - wbs), 0);
  endtask

  task automatic write_hit_bytes;
    word_addr_t a;
    word_t      rdata;
    int         latency;
    int         reqs;
    a    = make_addr(18'h00123, 8'h10, 2'd2, 2'd1);
    reqs = fill_reqs + wb_reqs;
    cpu_access(a, 32'ha5c3_7e19, 4'b0101, rdata, latency);
    ref_write(a, 32'ha5c3_7e19, 4'b0101);
    check_value("write hit latency", latency, 2);
    cpu_access(a, '0, '0, rdata, latency);
    check_value("read after byte write", rdata, ref_word(a));
    check_value("memory requests on write hit", fill_reqs + wb_reqs - reqs, 0);
  endtask

  task automatic dirty_eviction;
    word_addr_t old_a;
    word_addr_t new_a;
    word_addr_t w_addr;
    int         wbs;
    int         beats;
    old_a = make_addr(18'h00123, 8'h10, 2'd2, 2'd1);
    new_a = make_addr(18'h00456, 8'h10, 2'd0, 2'd3);
    wbs   = wb_reqs;
    beats = wb_beats;
    stall_left = 5;   // Hold off the first write-back beat
    read_check(new_a, "read after dirty eviction");
    check_value("write-back requests", wb_reqs - wbs, 1);
    check_value("write-back line address", wb_line, old_a[29:4]);
    check_value("beats before refill request", beats_at_fill - beats, 4);
    for (int w = 0; w < 16; w++) begin
      w_addr = {old_a[29:4], 4'(w)};
      check_value("written-back word", mem_word(w_addr), ref_word(w_addr));
    end
    read_check(old_a, "old address after eviction");
  endtask

  task automatic clean_eviction;
    word_addr_t a;
    word_addr_t b;
    int         fills;
    int         wbs;
    a = make_addr(18'h00777, 8'h20, 2'd1, 2'd2);
    b = make_addr(18'h03000, 8'h20, 2'd3, 2'd0);
    read_check(a, "first line of clean pair");
    fills = fill_reqs;
    wbs   = wb_reqs;
    read_check(b, "read after clean eviction");
    check_value("refills on clean eviction", fill_reqs - fills, 1);
    check_value("write-backs on clean eviction", wb_reqs - wbs, 0);
    check_value("clean eviction refill address", fill_line, b[29:4]);
  endtask

  task automatic random_traffic;
    tag_t        tags [3];
    index_t      indices [4];
    word_addr_t  touched [$];
    bit          seen [word_addr_t];
    word_addr_t  addr;
    word_t       data;
    word_t       rdata;
    byte_mask_t  mask;
    int          latency;
    logic [31:0] r;
    tags    = '{18'h00a01, 18'h01b02, 18'h2c003};
    indices = '{8'h40, 8'h41, 8'h80, 8'hc3};
    for (int i = 0; i < 300; i++) begin
      rng_state = xorshift(rng_state);
      r         = rng_state;
      addr      = make_addr(tags[r[1:0] % 3], indices[r[3:2]], r[5:4], r[7:6]);
      if (!seen.exists(addr)) begin
        seen[addr] = 1'b1;
        touched.push_back(addr);
      end
      if (r[8]) begin
        mask      = (r[12:9] == '0) ? 4'hf : r[12:9];
        rng_state = xorshift(rng_state);
        data      = rng_state;
        cpu_access(addr, data, mask, rdata, latency);
        ref_write(addr, data, mask);
      end else begin
        read_check(addr, "random read");
      end
    end
    foreach (touched[k]) begin
      read_check(touched[k], "final read-back");
    end
  endtask

  initial begin : main
    reset              = 1'b1;
    cpu_req_val        = 1'b0;
    cpu_req            = '0;
    mem_req_rdy        = 1'b0;
    mem_req_data_ready = 1'b1;
    mem_resp_val       = 1'b0;
    mem_resp_data      = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    read_miss_then_hit();
    write_hit_bytes();
    dirty_eviction();
    clean_eviction();
    random_traffic();

    repeat (4) @(posedge clk);
    if (dut.props.assert_failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== cache_properties.sv ====
`timescale 1ns/100ps

module cache_properties
  import mem_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     cpu_req_rdy,
  input logic     cpu_resp_val,
  input logic     mem_req_val,
  input logic     mem_req_rdy,
  input mem_req_t mem_req,
  input logic     mem_req_data_valid,
  input logic     mem_req_data_ready,
  input beat_t    mem_req_data_bits
);

  int   assert_failures = 0;
  logic reset_q;

  always_ff @(posedge clk) begin
    reset_q <= reset;
  end

  req_held: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req))
  else begin
    assert_failures++;
    $error("memory request dropped or changed before it was accepted");
  end

  wb_data_held: assert property (@(posedge clk) disable iff (reset)
    mem_req_data_valid && !mem_req_data_ready |=>
      mem_req_data_valid && $stable(mem_req_data_bits))
  else begin
    assert_failures++;
    $error("write-back beat changed while stalled");
  end

  // No response while idle as only one request is in flight
  resp_not_idle: assert property (@(posedge clk) disable iff (reset)
    !(cpu_resp_val && cpu_req_rdy))
  else begin
    assert_failures++;
    $error("response pulse while ready for a new request");
  end

  // From the second reset cycle on the FSM state is known
  quiet_in_reset: assert property (@(posedge clk)
    reset && reset_q |->
      !(cpu_req_rdy || cpu_resp_val || mem_req_val || mem_req_data_valid))
  else begin
    assert_failures++;
    $error("handshake strobe high during reset");
  end

endmodule

bind cache_top cache_properties props (.*);

// ==== cache_top.sv ====
`timescale 1ns/100ps

module cache_top
  import cache_pkg::*, mem_pkg::*;
(
  input  logic     clk,
  input  logic     reset,

  // CPU side
  input  logic     cpu_req_val,
  output logic     cpu_req_rdy,
  input  cpu_req_t cpu_req,
  output logic     cpu_resp_val,
  output word_t    cpu_resp_data,

  // Memory request and write-back data
  output logic     mem_req_val,
  input  logic     mem_req_rdy,
  output mem_req_t mem_req,
  output logic     mem_req_data_valid,
  input  logic     mem_req_data_ready,
  output beat_t    mem_req_data_bits,

  // Refill data
  input  logic     mem_resp_val,
  input  beat_t    mem_resp_data
);

  cache_ctrl_t ctrl;
  cache_stat_t stat;
  line_addr_t  mem_req_addr;
  logic        mem_req_rw;

  assign mem_req = '{addr: mem_req_addr, rw: mem_req_rw};

  cache_ctrl u_ctrl (
    .clk                (clk),
    .reset              (reset),
    .cpu_req_val        (cpu_req_val),
    .cpu_req_rdy        (cpu_req_rdy),
    .cpu_resp_val       (cpu_resp_val),
    .mem_req_val        (mem_req_val),
    .mem_req_rdy        (mem_req_rdy),
    .mem_req_rw         (mem_req_rw),
    .mem_req_data_valid (mem_req_data_valid),
    .mem_req_data_ready (mem_req_data_ready),
    .mem_resp_val       (mem_resp_val),
    .stat               (stat),
    .ctrl               (ctrl)
  );

  cache_datapath u_datapath (
    .clk               (clk),
    .reset             (reset),
    .cpu_req           (cpu_req),
    .ctrl              (ctrl),
    .stat              (stat),
    .cpu_resp_data     (cpu_resp_data),
    .mem_req_addr      (mem_req_addr),
    .mem_req_data_bits (mem_req_data_bits),
    .mem_resp_data     (mem_resp_data)
  );

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/100ps

module cache_ctrl
  import cache_pkg::*, mem_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        cpu_req_val,
  output logic        cpu_req_rdy,
  output logic        cpu_resp_val,
  output logic        mem_req_val,
  input  logic        mem_req_rdy,
  output logic        mem_req_rw,
  output logic        mem_req_data_valid,
  input  logic        mem_req_data_ready,
  input  logic        mem_resp_val,
  input  cache_stat_t stat,
  output cache_ctrl_t ctrl
);

  typedef enum logic [2:0] {
    st_init,
    st_idle,
    st_lookup,
    st_wb_req,
    st_wb_data,
    st_fill_req,
    st_fill_data,
    st_reread
  } state_t;

  state_t                     state;
  state_t                     next_state;
  index_t                     init_cnt;
  logic [beat_index_bits-1:0] beat_cnt;
  logic                       wb_gap;       // RAM read slot between write-back beats
  logic                       init_done;
  logic                       last_beat;
  logic                       wb_beat_fire;
  logic                       fill_beat;

  assign init_done    = (init_cnt == index_t'(num_lines - 1));
  assign last_beat    = (beat_cnt == beat_index_bits'(beats_per_line - 1));
  assign wb_beat_fire = (state == st_wb_data) && !wb_gap && mem_req_data_ready;
  assign fill_beat    = (state == st_fill_data) && mem_resp_val;

  //////////////////////////////////////////////////////////////////////
  // State and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_init;
      init_cnt <= '0;
      beat_cnt <= '0;
      wb_gap   <= 1'b0;
    end else begin
      state <= next_state;
      if (state == st_init) begin
        init_cnt <= init_cnt + 1'b1;
      end
      // Wraps back to zero after the last beat
      if (wb_beat_fire || fill_beat) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      if (state == st_wb_data) begin
        wb_gap <= wb_beat_fire && !last_beat;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state and strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state         = state;
    ctrl               = '0;
    ctrl.beat          = beat_cnt;
    ctrl.init_index    = init_cnt;
    cpu_req_rdy        = 1'b0;
    cpu_resp_val       = 1'b0;
    mem_req_val        = 1'b0;
    mem_req_rw         = 1'b0;
    mem_req_data_valid = 1'b0;

    case (state)
      st_init: begin
        ctrl.tag_wr     = 1'b1;         // Clear one tag per cycle
        ctrl.tag_update = tag_invalidate;
        if (init_done) begin
          next_state = st_idle;
        end
      end

      st_idle: begin
        cpu_req_rdy  = 1'b1;
        ctrl.capture = cpu_req_val;
        if (cpu_req_val) begin
          next_state = st_lookup;
        end
      end

      st_lookup: begin
        if (stat.hit) begin
          cpu_resp_val    = !stat.is_write;
          ctrl.data_wr    = stat.is_write;   // Merged beat back into the line
          ctrl.tag_wr     = stat.is_write;
          ctrl.tag_update = tag_mark_dirty;
          next_state      = st_idle;
        end else if (stat.victim_dirty) begin
          next_state = st_wb_req;
        end else begin
          next_state = st_fill_req;
        end
      end

      st_wb_req: begin
        mem_req_val = 1'b1;
        mem_req_rw  = 1'b1;
        ctrl.wb_rd  = 1'b1;   // Beat 0 ready once the request is taken
        if (mem_req_rdy) begin
          next_state = st_wb_data;
        end
      end

      st_wb_data: begin
        ctrl.wb_rd         = wb_gap;
        mem_req_data_valid = !wb_gap;
        if (wb_beat_fire && last_beat) begin
          next_state = st_fill_req;
        end
      end

      st_fill_req: begin
        mem_req_val = 1'b1;
        if (mem_req_rdy) begin
          next_state = st_fill_data;
        end
      end

      st_fill_data: begin
        ctrl.fill_src = 1'b1;
        ctrl.data_wr  = mem_resp_val;
        if (fill_beat && last_beat) begin
          ctrl.tag_wr     = 1'b1;
          ctrl.tag_update = tag_fill_clean;
          next_state      = st_reread;
        end
      end

      st_reread: begin
        ctrl.lookup_rd = 1'b1;  // Second lookup, now a hit
        next_state     = st_lookup;
      end

      default: begin
        next_state = st_init;
      end
    endcase
  end

endmodule

// ==== cache_datapath.sv ====
`timescale 1ns/100ps

module cache_datapath
  import cache_pkg::*, mem_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  cpu_req_t    cpu_req,
  input  cache_ctrl_t ctrl,
  output cache_stat_t stat,
  output word_t       cpu_resp_data,
  output line_addr_t  mem_req_addr,
  output beat_t       mem_req_data_bits,
  input  beat_t       mem_resp_data
);

  cpu_req_t                   req_q;
  index_t                     req_index;
  index_t                     line_index;
  logic [beat_index_bits-1:0] beat_sel;
  logic [word_sel_bits-1:0]   word_sel;
  logic                       sweep;
  tag_entry_t                 tag_rdata;
  tag_entry_t                 tag_wdata;
  beat_t                      data_rdata;
  beat_t                      data_wdata;
  beat_t                      merged;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q.wmask <= '0;
    end else if (ctrl.capture) begin
      req_q <= cpu_req;
    end
  end

  assign req_index = addr_index(req_q.addr);
  assign word_sel  = addr_word(req_q.addr);
  assign sweep     = ctrl.tag_wr && (ctrl.tag_update == tag_invalidate);

  //////////////////////////////////////////////////////////////////////
  // RAM addressing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (ctrl.capture) begin
      line_index = addr_index(cpu_req.addr);  // Lookup of the incoming request
      beat_sel   = addr_beat(cpu_req.addr);
    end else begin
      line_index = sweep ? ctrl.init_index : req_index;
      beat_sel   = (ctrl.wb_rd || ctrl.fill_src) ? ctrl.beat : addr_beat(req_q.addr);
    end
  end

  always_comb begin
    tag_wdata = '0;
    case (ctrl.tag_update)
      tag_fill_clean: tag_wdata = '{valid: 1'b1, dirty: 1'b0, tag: addr_tag(req_q.addr)};
      tag_mark_dirty: tag_wdata = '{valid: 1'b1, dirty: 1'b1, tag: addr_tag(req_q.addr)};
      default:        tag_wdata = '0;
    endcase
  end

  sram_1rw #(
    .payload_t (tag_entry_t),
    .depth     (num_lines)
  ) tag_ram (
    .clk   (clk),
    .en    (ctrl.capture | ctrl.lookup_rd | ctrl.tag_wr),
    .we    (ctrl.tag_wr),
    .addr  (line_index),
    .wdata (tag_wdata),
    .rdata (tag_rdata)
  );

  sram_1rw #(
    .payload_t (beat_t),
    .depth     (num_lines * beats_per_line)
  ) data_ram (
    .clk   (clk),
    .en    (ctrl.capture | ctrl.lookup_rd | ctrl.wb_rd | ctrl.data_wr),
    .we    (ctrl.data_wr),
    .addr  ({line_index, beat_sel}),
    .wdata (data_wdata),
    .rdata (data_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Hit detection, word select and store merge
  //////////////////////////////////////////////////////////////////////

  assign stat.hit          = tag_rdata.valid && (tag_rdata.tag == addr_tag(req_q.addr));
  assign stat.victim_dirty = tag_rdata.valid && tag_rdata.dirty;
  assign stat.is_write     = |req_q.wmask;

  assign cpu_resp_data = data_rdata[word_sel*word_bits +: word_bits];

  // Store bytes go into the beat read during lookup
  always_comb begin
    merged = data_rdata;
    for (int b = 0; b < word_bits/8; b++) begin
      if (req_q.wmask[b]) begin
        merged[word_sel*word_bits + b*8 +: 8] = req_q.data[b*8 +: 8];
      end
    end
  end

  assign data_wdata = ctrl.fill_src ? mem_resp_data : merged;

  // Victim line while writing back, else the missing line
  assign mem_req_addr      = ctrl.wb_rd ? {tag_rdata.tag, req_index}
                                        : {addr_tag(req_q.addr), req_index};
  assign mem_req_data_bits = data_rdata;

endmodule

// ==== sram_1rw.sv ====
`timescale 1ns/100ps

module sram_1rw #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 256
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] addr,
  input  payload_t                 wdata,
  output payload_t                 rdata
);

  payload_t mem [depth];

  // Single port, read and write never in the same cycle
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];  // Holds until the next read
      end
    end
  end

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

  // Memory side of the cache, one 128-bit beat per transfer
  localparam int beat_bits       = 128;
  localparam int beats_per_line  = 4;
  localparam int beat_index_bits = $clog2(beats_per_line);

  // Line address drops the beat and word fields of a word address
  localparam int line_addr_bits  = 26;

  typedef logic [beat_bits-1:0]      beat_t;
  typedef logic [line_addr_bits-1:0] line_addr_t;

  typedef struct packed {
    line_addr_t addr;
    logic       rw;     // 1 for write-back, 0 for refill
  } mem_req_t;

endpackage

// ==== cache_pkg.sv ====
package cache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////////////////////////

  localparam int num_lines      = 256;
  localparam int index_bits     = 8;
  localparam int word_addr_bits = 30;
  localparam int word_bits      = 32;
  localparam int words_per_beat = 4;

  // Word address layout is tag | index | beat | word
  localparam int word_sel_bits  = $clog2(words_per_beat);
  localparam int index_lsb      = word_sel_bits + 2;      // Two beat bits below the index
  localparam int tag_lsb        = index_lsb + index_bits;
  localparam int tag_bits       = word_addr_bits - tag_lsb;

  typedef logic [word_addr_bits-1:0] word_addr_t;
  typedef logic [word_bits-1:0]      word_t;
  typedef logic [word_bits/8-1:0]    byte_mask_t;
  typedef logic [index_bits-1:0]     index_t;
  typedef logic [tag_bits-1:0]       tag_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef struct packed {
    word_addr_t addr;
    word_t      data;
    byte_mask_t wmask;  // All zero for a read
  } cpu_req_t;

  typedef enum logic [1:0] {
    tag_invalidate,
    tag_fill_clean,
    tag_mark_dirty
  } tag_update_t;

  // Controller to datapath
  typedef struct packed {
    logic        capture;
    logic        lookup_rd;
    logic        tag_wr;
    tag_update_t tag_update;
    logic        data_wr;
    logic        fill_src;    // Memory beat instead of merged store
    logic [1:0]  beat;
    logic        wb_rd;
    index_t      init_index;
  } cache_ctrl_t;

  // Datapath to controller, meaningful in lookup
  typedef struct packed {
    logic hit;
    logic victim_dirty;
    logic is_write;
  } cache_stat_t;

  function automatic index_t addr_index(word_addr_t addr);
    return addr[index_lsb +: index_bits];
  endfunction

  function automatic tag_t addr_tag(word_addr_t addr);
    return addr[tag_lsb +: tag_bits];
  endfunction

  function automatic logic [1:0] addr_beat(word_addr_t addr);
    return addr[index_lsb-1:word_sel_bits];
  endfunction

  function automatic logic [word_sel_bits-1:0] addr_word(word_addr_t addr);
    return addr[word_sel_bits-1:0];
  endfunction

endpackage
